// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_addr \
		-f sim.f -o tb_tile_addr
	./obj_dir/tb_tile_addr

clean:
	rm -rf obj_dir

// File: rtl/cfg_axil.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_axil (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [7:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    input  logic frame_done,
    output logic start,
    output logic [tile_pkg::coord_w-1:0] ix,
    output logic [tile_pkg::coord_w-1:0] iy,
    output logic [tile_pkg::geom_w-1:0] k,
    output logic [tile_pkg::geom_w-1:0] s,
    output logic [tile_pkg::geom_w-1:0] p,
    output logic [tile_pkg::coord_w-1:0] pox,
    output logic [tile_pkg::coord_w-1:0] poy,
    output logic [tile_pkg::coord_w-1:0] ox_total,
    output logic [tile_pkg::coord_w-1:0] oy_total
);

    logic wr_en;
    logic rd_en;
    logic busy;
    logic done;
    logic [31:0] wmask;
    logic [31:0] rd_word;

    // take aw and w together, one write in flight
    assign wr_en = awvalid & wvalid & ~bvalid;
    assign awready = wr_en;
    assign wready = wr_en;
    assign rd_en = arvalid & ~rvalid;
    assign arready = rd_en;
    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    assign wmask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

    // ctrl bit 0, dropped while a frame runs
    assign start = wr_en && (awaddr == tile_pkg::reg_ctrl) && wstrb[0] && wdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    ////////////////////
    // layer registers
    ////////////////////

    // frozen while busy so the walkers see a static layer
    always_ff @(posedge clk) begin
        if (reset) begin
            ix <= '0;
            iy <= '0;
            k <= 4'd1;
            s <= 4'd1;
            p <= '0;
            pox <= '0;
            poy <= '0;
            ox_total <= '0;
            oy_total <= '0;
        end else if (wr_en && !busy) begin
            case (awaddr)
                tile_pkg::reg_ix: ix <= (ix & ~wmask[15:0]) | (wdata[15:0] & wmask[15:0]);
                tile_pkg::reg_iy: iy <= (iy & ~wmask[15:0]) | (wdata[15:0] & wmask[15:0]);
                tile_pkg::reg_kernel: begin
                    if (wstrb[0]) begin
                        k <= wdata[3:0];
                        // only strides 1 and 2
                        s <= (wdata[7:4] == 4'd2) ? 4'd2 : 4'd1;
                    end
                    if (wstrb[1]) begin
                        p <= wdata[11:8];
                    end
                end
                tile_pkg::reg_tile: begin
                    pox <= (pox & ~wmask[15:0]) | (wdata[15:0] & wmask[15:0]);
                    poy <= (poy & ~wmask[31:16]) | (wdata[31:16] & wmask[31:16]);
                end
                tile_pkg::reg_out: begin
                    ox_total <= (ox_total & ~wmask[15:0]) | (wdata[15:0] & wmask[15:0]);
                    oy_total <= (oy_total & ~wmask[31:16]) | (wdata[31:16] & wmask[31:16]);
                end
                default: ;
            endcase
        end
    end

    // busy drops as done rises
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (frame_done) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    ////////////////////
    // read path
    ////////////////////

    always_comb begin
        case (araddr)
            tile_pkg::reg_status: rd_word = {30'b0, done, busy};
            tile_pkg::reg_ix: rd_word = {16'b0, ix};
            tile_pkg::reg_iy: rd_word = {16'b0, iy};
            tile_pkg::reg_kernel: rd_word = {20'b0, p, s, k};
            tile_pkg::reg_tile: rd_word = {poy, pox};
            tile_pkg::reg_out: rd_word = {oy_total, ox_total};
            // ctrl and holes read zero
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/conv_row.sv
`timescale 1ns/1ps
`default_nettype none

module conv_row #(
    parameter int pixels_in_row = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic row_go,
    input  logic [tile_pkg::coord_w-1:0] row_y,
    input  logic [tile_pkg::coord_w-1:0] ix,
    input  logic [tile_pkg::coord_w-1:0] ox_start,
    input  logic [tile_pkg::coord_w-1:0] tile_pox,
    input  logic [tile_pkg::geom_w-1:0] k,
    input  logic [tile_pkg::geom_w-1:0] s,
    input  logic [tile_pkg::geom_w-1:0] p,
    input  logic req_ready,
    output logic req_valid,
    output logic [tile_pkg::coord_w-1:0] row_idx,
    output logic [tile_pkg::pad_w-1:0] west_pad,
    output logic [tile_pkg::pad_w-1:0] east_pad,
    output logic [tile_pkg::pad_w-1:0] slab_num,
    output logic [tile_pkg::coord_w-1:0] row_start_idx,
    output logic [tile_pkg::coord_w-1:0] row_end_idx,
    output logic [tile_pkg::coord_w-1:0] reg_start_idx,
    output logic [tile_pkg::coord_w-1:0] reg_end_idx,
    output logic row_done
);

    localparam int cw = tile_pkg::coord_w;
    localparam int gw = tile_pkg::geom_w;
    localparam int pw = tile_pkg::pad_w;
    // signed span math, room for negative columns
    localparam int sw = cw + 2;
    localparam int sh = $clog2(pixels_in_row);

    logic s2;
    logic [cw-1:0] ox_off;
    logic [cw-1:0] span;
    logic signed [sw-1:0] first;
    logic signed [sw-1:0] last;
    logic signed [sw-1:0] ix_s;
    logic [cw-1:0] start_c;
    logic [cw-1:0] end_c;
    logic [cw-1:0] start_m1;
    logic [cw-1:0] end_m1;
    logic [pw-1:0] west_c;
    logic [pw-1:0] east_c;
    logic [pw-1:0] slab_c;

    ////////////////////
    // column span
    ////////////////////

    assign s2 = (s == gw'(2));
    assign ox_off = s2 ? (ox_start - 1'b1) << 1 : ox_start - 1'b1;
    // (tile_pox - 1) * s + k - 1
    assign span = (s2 ? (tile_pox - 1'b1) << 1 : tile_pox - 1'b1) + cw'(k) - 1'b1;
    assign first = $signed({2'b00, ox_off}) + 1 - $signed(sw'(p));
    assign last = first + $signed({2'b00, span});
    assign ix_s = $signed({2'b00, ix});

    // clip to 1..ix, the overhang is padding
    assign start_c = (first < 1) ? cw'(1) : first[cw-1:0];
    assign end_c = (last > ix_s) ? ix : last[cw-1:0];
    assign west_c = (first < 1) ? pw'(1 - first) : '0;
    assign east_c = (last > ix_s) ? pw'(last - ix_s) : '0;

    // zero-based pixel positions, slab index in the high bits
    assign start_m1 = start_c - 1'b1;
    assign end_m1 = end_c - 1'b1;
    assign slab_c = pw'((end_m1 >> sh) - (start_m1 >> sh) + 1'b1);

    ////////////////////
    // request hold
    ////////////////////

    assign row_done = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (row_go) begin
            req_valid <= 1'b1;
        end else if (row_done) begin
            req_valid <= 1'b0;
        end
    end

    // fields load once per request and stay put under back-pressure
    always_ff @(posedge clk) begin
        if (row_go) begin
            row_idx <= row_y;
            west_pad <= west_c;
            east_pad <= east_c;
            slab_num <= slab_c;
            row_start_idx <= start_c;
            row_end_idx <= end_c;
            reg_start_idx <= start_m1 & cw'(pixels_in_row - 1);
            reg_end_idx <= end_m1 & cw'(pixels_in_row - 1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/conv_tile.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tile (
    input  logic clk,
    input  logic reset,
    input  logic tile_en,
    input  logic [tile_pkg::coord_w-1:0] oy_start,
    input  logic [tile_pkg::coord_w-1:0] tile_poy,
    input  logic [tile_pkg::coord_w-1:0] iy,
    input  logic [tile_pkg::geom_w-1:0] k,
    input  logic [tile_pkg::geom_w-1:0] s,
    input  logic [tile_pkg::geom_w-1:0] p,
    input  logic row_done1,
    input  logic row_done2,
    input  logic row_done3,
    output logic [tile_pkg::coord_w-1:0] row_y1,
    output logic [tile_pkg::coord_w-1:0] row_y2,
    output logic [tile_pkg::coord_w-1:0] row_y3,
    output logic row_go1,
    output logic row_go2,
    output logic row_go3,
    output logic tile_end
);

    localparam int nb = tile_pkg::buffers_num;
    localparam int cw = tile_pkg::coord_w;
    localparam int gw = tile_pkg::geom_w;

    logic s2;
    logic [cw-1:0] s_step;
    logic [cw-1:0] iy_start;
    logic [cw-1:0] p_lo;
    logic [cw-1:0] p_hi;
    logic [gw-1:0] ky [nb];
    logic [cw-1:0] irow [nb];
    logic [cw-1:0] lim [nb];
    logic [cw-1:0] padded [nb];
    logic [cw-1:0] lane_y [nb];
    logic [nb-1:0] done_v;
    logic [nb-1:0] ky_last;
    logic [nb-1:0] lane_end;
    logic [nb-1:0] go_q;
    logic [nb-1:0] fin;

    // stride is 1 or 2, so a shift stands in for the multiply
    assign s2 = (s == gw'(2));
    assign s_step = s2 ? cw'(2 * nb) : cw'(nb);
    // iy_start = (oy_start - 1) * s + 1
    assign iy_start = s2 ? (oy_start << 1) - 1'b1 : oy_start;
    // padded rows p+1 .. p+iy hold real data
    assign p_lo = cw'(p) + 1'b1;
    assign p_hi = cw'(p) + iy;

    assign done_v = {row_done3, row_done2, row_done1};

    ////////////////////
    // per-lane rows
    ////////////////////

    always_comb begin
        for (int b = 0; b < nb; b++) begin
            // last output-row offset of lane b, floored at zero
            if (tile_poy > cw'(b + 1)) begin
                lim[b] = s2 ? (tile_poy - cw'(b + 1)) << 1 : tile_poy - cw'(b + 1);
            end else begin
                lim[b] = '0;
            end
            padded[b] = iy_start + (s2 ? cw'(2 * b) : cw'(b)) + irow[b] + cw'(ky[b]);
            lane_y[b] = (padded[b] < p_lo || padded[b] > p_hi) ? tile_pkg::row_none
                                                                : padded[b] - cw'(p);
            ky_last[b] = (ky[b] == k - 1'b1);
            lane_end[b] = done_v[b] && ky_last[b] && (irow[b] + s_step > lim[b]);
        end
    end

    // ky inner, irow outer
    always_ff @(posedge clk) begin
        for (int b = 0; b < nb; b++) begin
            if (reset) begin
                ky[b] <= '0;
                irow[b] <= '0;
            end else if (done_v[b]) begin
                if (ky_last[b]) begin
                    ky[b] <= '0;
                    irow[b] <= lane_end[b] ? '0 : irow[b] + s_step;
                end else begin
                    ky[b] <= ky[b] + 1'b1;
                end
            end
        end
    end

    // next pair one cycle after the accept, counters settled by then
    always_ff @(posedge clk) begin
        if (reset) begin
            go_q <= '0;
            fin <= '0;
        end else begin
            go_q <= done_v & ~lane_end;
            fin <= tile_end ? '0 : (fin | lane_end);
        end
    end

    // all lanes parked
    assign tile_end = &fin;

    assign row_y1 = lane_y[0];
    assign row_y2 = lane_y[1];
    assign row_y3 = lane_y[2];
    assign row_go1 = tile_en | go_q[0];
    assign row_go2 = tile_en | go_q[1];
    assign row_go3 = tile_en | go_q[2];

endmodule

`default_nettype wire

// File: rtl/loop_tiling.sv
`timescale 1ns/1ps
`default_nettype none

module loop_tiling (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [tile_pkg::coord_w-1:0] pox,
    input  logic [tile_pkg::coord_w-1:0] poy,
    input  logic [tile_pkg::coord_w-1:0] ox_total,
    input  logic [tile_pkg::coord_w-1:0] oy_total,
    input  logic tile_end,
    output logic tile_en,
    output logic [tile_pkg::coord_w-1:0] ox_start,
    output logic [tile_pkg::coord_w-1:0] oy_start,
    output logic [tile_pkg::coord_w-1:0] tile_pox,
    output logic [tile_pkg::coord_w-1:0] tile_poy,
    output logic frame_done
);

    typedef enum logic {st_idle, st_run} state_t;

    state_t state;
    // one spare bit for the carry past the map edge
    logic [tile_pkg::coord_w:0] ox_next;
    logic [tile_pkg::coord_w:0] oy_next;
    logic [tile_pkg::coord_w-1:0] ox_left;
    logic [tile_pkg::coord_w-1:0] oy_left;
    logic row_last;
    logic col_last;

    assign ox_next = ox_start + pox;
    assign oy_next = oy_start + poy;
    assign row_last = ox_next > {1'b0, ox_total};
    assign col_last = oy_next > {1'b0, oy_total};

    // clip the last tile of a row or column
    assign ox_left = ox_total - ox_start + 1'b1;
    assign oy_left = oy_total - oy_start + 1'b1;
    assign tile_pox = (ox_left < pox) ? ox_left : pox;
    assign tile_poy = (oy_left < poy) ? oy_left : poy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            tile_en <= 1'b0;
            frame_done <= 1'b0;
            ox_start <= 1;
            oy_start <= 1;
        end else begin
            tile_en <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                st_idle: begin
                    // origin is 1-based
                    if (start) begin
                        ox_start <= 1;
                        oy_start <= 1;
                        tile_en <= 1'b1;
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (tile_end) begin
                        if (!row_last) begin
                            // step along the row
                            ox_start <= ox_next[tile_pkg::coord_w-1:0];
                            tile_en <= 1'b1;
                        end else if (!col_last) begin
                            // wrap to the next tile row
                            ox_start <= 1;
                            oy_start <= oy_next[tile_pkg::coord_w-1:0];
                            tile_en <= 1'b1;
                        end else begin
                            frame_done <= 1'b1;
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tile_addr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tile_addr_top #(
    parameter int pixels_in_row = 32
) (
    input  logic clk,
    input  logic reset,
    // AXI4-Lite slave
    input  logic [7:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [7:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    // row request lanes
    output logic req_valid1, req_valid2, req_valid3,
    input  logic req_ready1, req_ready2, req_ready3,
    output logic [tile_pkg::coord_w-1:0] row_idx1, row_idx2, row_idx3,
    output logic [tile_pkg::pad_w-1:0] west_pad1, west_pad2, west_pad3,
    output logic [tile_pkg::pad_w-1:0] east_pad1, east_pad2, east_pad3,
    output logic [tile_pkg::pad_w-1:0] slab_num1, slab_num2, slab_num3,
    output logic [tile_pkg::coord_w-1:0] row_start_idx1, row_start_idx2, row_start_idx3,
    output logic [tile_pkg::coord_w-1:0] row_end_idx1, row_end_idx2, row_end_idx3,
    output logic [tile_pkg::coord_w-1:0] reg_start_idx1, reg_start_idx2, reg_start_idx3,
    output logic [tile_pkg::coord_w-1:0] reg_end_idx1, reg_end_idx2, reg_end_idx3
);

    // layer config
    logic start;
    logic frame_done;
    logic [tile_pkg::coord_w-1:0] ix, iy, pox, poy, ox_total, oy_total;
    logic [tile_pkg::geom_w-1:0] k, s, p;
    // current tile
    logic tile_en;
    logic tile_end;
    logic [tile_pkg::coord_w-1:0] ox_start, oy_start, tile_pox, tile_poy;
    // lane handshake
    logic [tile_pkg::coord_w-1:0] row_y1, row_y2, row_y3;
    logic row_go1, row_go2, row_go3;
    logic row_done1, row_done2, row_done3;

    cfg_axil cfg_axil_inst (.*);

    loop_tiling loop_tiling_inst (.*);

    conv_tile conv_tile_inst (.*);

    conv_row #(.pixels_in_row(pixels_in_row)) conv_row_inst1 (
        .clk, .reset, .row_go(row_go1), .row_y(row_y1), .ix, .ox_start, .tile_pox,
        .k, .s, .p, .req_ready(req_ready1), .req_valid(req_valid1), .row_idx(row_idx1),
        .west_pad(west_pad1), .east_pad(east_pad1), .slab_num(slab_num1),
        .row_start_idx(row_start_idx1), .row_end_idx(row_end_idx1),
        .reg_start_idx(reg_start_idx1), .reg_end_idx(reg_end_idx1), .row_done(row_done1)
    );

    conv_row #(.pixels_in_row(pixels_in_row)) conv_row_inst2 (
        .clk, .reset, .row_go(row_go2), .row_y(row_y2), .ix, .ox_start, .tile_pox,
        .k, .s, .p, .req_ready(req_ready2), .req_valid(req_valid2), .row_idx(row_idx2),
        .west_pad(west_pad2), .east_pad(east_pad2), .slab_num(slab_num2),
        .row_start_idx(row_start_idx2), .row_end_idx(row_end_idx2),
        .reg_start_idx(reg_start_idx2), .reg_end_idx(reg_end_idx2), .row_done(row_done2)
    );

    conv_row #(.pixels_in_row(pixels_in_row)) conv_row_inst3 (
        .clk, .reset, .row_go(row_go3), .row_y(row_y3), .ix, .ox_start, .tile_pox,
        .k, .s, .p, .req_ready(req_ready3), .req_valid(req_valid3), .row_idx(row_idx3),
        .west_pad(west_pad3), .east_pad(east_pad3), .slab_num(slab_num3),
        .row_start_idx(row_start_idx3), .row_end_idx(row_end_idx3),
        .reg_start_idx(reg_start_idx3), .reg_end_idx(reg_end_idx3), .row_done(row_done3)
    );

endmodule

`default_nettype wire

// File: rtl/tile_pkg.sv
`default_nettype none

package tile_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // one lane per line buffer
    localparam int buffers_num = 3;

    // coordinates and sizes
    localparam int coord_w = 16;
    // k, s and p fields
    localparam int geom_w = 4;
    // west_pad, east_pad, slab_num
    localparam int pad_w = 4;

    // input row marker for a padding row
    localparam logic [coord_w-1:0] row_none = '1;

    ////////////////////
    // register map
    ////////////////////

    // byte offsets of 32-bit words
    localparam logic [7:0] reg_ctrl   = 8'h00;
    localparam logic [7:0] reg_status = 8'h04;
    localparam logic [7:0] reg_ix     = 8'h08;
    localparam logic [7:0] reg_iy     = 8'h0c;
    // k [3:0], s [7:4], p [11:8]
    localparam logic [7:0] reg_kernel = 8'h10;
    // pox low half, poy high half
    localparam logic [7:0] reg_tile   = 8'h14;
    // ox_total low half, oy_total high half
    localparam logic [7:0] reg_out    = 8'h18;

endpackage

`default_nettype wire

// File: sim.f
rtl/tile_pkg.sv
rtl/cfg_axil.sv
rtl/loop_tiling.sv
rtl/conv_tile.sv
rtl/conv_row.sv
rtl/tile_addr_top.sv
test/tb_tile_addr.sv

// File: test/tb_tile_addr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_addr;

    localparam int pir = 32;
    localparam int layers = 8;
    localparam int depth = 8192;

    logic clk;
    logic reset;
    logic [7:0] awaddr;
    logic awvalid;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic bready;
    logic [7:0] araddr;
    logic arvalid;
    logic rready;
    logic [2:0] rdy;
    wire awready;
    wire wready;
    wire [1:0] bresp;
    wire bvalid;
    wire arready;
    wire [31:0] rdata;
    wire [1:0] rresp;
    wire rvalid;
    wire [2:0] vld;
    // row_idx, west, east, slab, row start/end, slab start/end
    wire [2:0][91:0] got;

    // random streams
    logic [31:0] cfg_st;
    logic [31:0] rdy_st;
    // current layer
    int lx, ly, lk, ls, lp, lpox, lpoy, lox, loy, s_wr;
    // expected requests per lane
    logic [91:0] exp_mem [3][depth];
    int exp_cnt [3];
    int got_cnt [3];
    // request held under back-pressure
    logic [2:0] held;
    logic [2:0][91:0] held_val;

    tile_addr_top #(.pixels_in_row(pir)) tile_addr_top_inst (
        .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid,
        .rready,
        .req_valid1(vld[0]), .req_valid2(vld[1]), .req_valid3(vld[2]),
        .req_ready1(rdy[0]), .req_ready2(rdy[1]), .req_ready3(rdy[2]),
        .row_idx1(got[0][91:76]), .row_idx2(got[1][91:76]), .row_idx3(got[2][91:76]),
        .west_pad1(got[0][75:72]), .west_pad2(got[1][75:72]), .west_pad3(got[2][75:72]),
        .east_pad1(got[0][71:68]), .east_pad2(got[1][71:68]), .east_pad3(got[2][71:68]),
        .slab_num1(got[0][67:64]), .slab_num2(got[1][67:64]), .slab_num3(got[2][67:64]),
        .row_start_idx1(got[0][63:48]), .row_start_idx2(got[1][63:48]),
        .row_start_idx3(got[2][63:48]),
        .row_end_idx1(got[0][47:32]), .row_end_idx2(got[1][47:32]),
        .row_end_idx3(got[2][47:32]),
        .reg_start_idx1(got[0][31:16]), .reg_start_idx2(got[1][31:16]),
        .reg_start_idx3(got[2][31:16]),
        .reg_end_idx1(got[0][15:0]), .reg_end_idx2(got[1][15:0]),
        .reg_end_idx3(got[2][15:0])
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // random bits
    ////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
    endfunction

    // one step per bit taken
    task automatic take_bits(inout logic [31:0] st, input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v = (v << 1) | int'(st[0]);
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_field(input string name, input int lane, input logic [15:0] g,
                               input logic [15:0] e);
        assert (g == e) else
            fail_run($sformatf("MISMATCH t=%0t %s%0d got %h exp %h", $time, name, lane + 1,
                               g, e));
    endtask

    task automatic compare_req(input int lane, input logic [91:0] g, input logic [91:0] e);
        check_field("row_idx", lane, g[91:76], e[91:76]);
        check_field("west_pad", lane, 16'(g[75:72]), 16'(e[75:72]));
        check_field("east_pad", lane, 16'(g[71:68]), 16'(e[71:68]));
        check_field("slab_num", lane, 16'(g[67:64]), 16'(e[67:64]));
        check_field("row_start_idx", lane, g[63:48], e[63:48]);
        check_field("row_end_idx", lane, g[47:32], e[47:32]);
        check_field("reg_start_idx", lane, g[31:16], e[31:16]);
        check_field("reg_end_idx", lane, g[15:0], e[15:0]);
    endtask

    task automatic check_reg(input string name, input logic [31:0] g, input logic [31:0] e);
        assert (g == e) else
            fail_run($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, g, e));
    endtask

    ////////////////////
    // AXI4-Lite master
    ////////////////////

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!awready) begin
            n++;
            assert (n < 20) else fail_run("timeout waiting for awready");
            @(posedge clk);
        end
        // address and data taken in the same cycle
        check_reg("wready", 32'(wready), 32'h1);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        n = 0;
        @(posedge clk);
        while (!bvalid) begin
            n++;
            assert (n < 20) else fail_run("timeout waiting for the write response");
            @(posedge clk);
        end
        check_reg("bresp", 32'(bresp), 32'h0);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!arready) begin
            n++;
            assert (n < 20) else fail_run("timeout waiting for arready");
            @(posedge clk);
        end
        #1;
        arvalid = 1'b0;
        rready = 1'b1;
        n = 0;
        @(posedge clk);
        while (!rvalid) begin
            n++;
            assert (n < 20) else fail_run("timeout waiting for read data");
            @(posedge clk);
        end
        check_reg("rresp", 32'(rresp), 32'h0);
        data = rdata;
        #1;
        rready = 1'b0;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    task automatic draw_layer(input int idx);
        int r;
        take_bits(cfg_st, 2, r);
        lk = r % 3 + 1;
        take_bits(cfg_st, 1, r);
        ls = r + 1;
        take_bits(cfg_st, 2, r);
        // padding below the kernel size
        lp = r % lk;
        take_bits(cfg_st, 6, r);
        lx = r % 48 + 3;
        take_bits(cfg_st, 4, r);
        ly = r % 12 + 3;
        take_bits(cfg_st, 3, r);
        lpox = r + 1;
        take_bits(cfg_st, 3, r);
        lpoy = r % 7 + 1;
        take_bits(cfg_st, 1, r);
        // stride 3 folds to 1
        s_wr = (ls == 1 && r != 0) ? 3 : ls;
        if (idx == 0) begin
            lk = 3;
            ls = 1;
            s_wr = 3;
            lp = 2;
        end else if (idx == 1) begin
            lk = 3;
            ls = 2;
            s_wr = 2;
            lp = 1;
        end
        lox = (lx + 2 * lp - lk) / ls + 1;
        loy = (ly + 2 * lp - lk) / ls + 1;
    endtask

    task automatic build_model;
        int tpx, tpy, first, last, w, e, rs, re, sl, lim, pr, ry;
        for (int b = 0; b < 3; b++) begin
            exp_cnt[b] = 0;
            got_cnt[b] = 0;
        end
        // tiles along a row first
        for (int oys = 1; oys <= loy; oys += lpoy) begin
            for (int oxs = 1; oxs <= lox; oxs += lpox) begin
                tpx = (lox - oxs + 1 < lpox) ? lox - oxs + 1 : lpox;
                tpy = (loy - oys + 1 < lpoy) ? loy - oys + 1 : lpoy;
                // column span before clipping
                first = (oxs - 1) * ls + 1 - lp;
                last = first + (tpx - 1) * ls + lk - 1;
                w = (first < 1) ? 1 - first : 0;
                e = (last > lx) ? last - lx : 0;
                rs = (first < 1) ? 1 : first;
                re = (last > lx) ? lx : last;
                sl = (re - 1) / pir - (rs - 1) / pir + 1;
                for (int b = 0; b < 3; b++) begin
                    lim = (tpy - 1 - b > 0) ? (tpy - 1 - b) * ls : 0;
                    for (int irow = 0; irow <= lim; irow += 3 * ls) begin
                        for (int ky = 0; ky < lk; ky++) begin
                            pr = (oys - 1) * ls + 1 + b * ls + irow + ky;
                            ry = (pr < lp + 1 || pr > lp + ly) ? 16'hffff : pr - lp;
                            assert (exp_cnt[b] < depth) else fail_run("model table overflow");
                            exp_mem[b][exp_cnt[b]] = {16'(ry), 4'(w), 4'(e), 4'(sl),
                                                      16'(rs), 16'(re), 16'((rs - 1) % pir),
                                                      16'((re - 1) % pir)};
                            exp_cnt[b]++;
                        end
                    end
                end
            end
        end
    endtask

    ////////////////////
    // lanes
    ////////////////////

    // ready high three times in four
    always @(posedge clk) begin
        int r;
        #1;
        for (int b = 0; b < 3; b++) begin
            take_bits(rdy_st, 2, r);
            rdy[b] = (r != 0);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            held = '0;
        end else begin
            for (int b = 0; b < 3; b++) begin
                if (held[b]) begin
                    assert (vld[b]) else
                        fail_run($sformatf("lane %0d dropped a request before accept", b + 1));
                    compare_req(b, got[b], held_val[b]);
                end
                if (vld[b]) begin
                    assert (got_cnt[b] < exp_cnt[b]) else
                        fail_run($sformatf("lane %0d raised a request beyond the expected %0d",
                                           b + 1, exp_cnt[b]));
                    if (rdy[b]) begin
                        compare_req(b, got[b], exp_mem[b][got_cnt[b]]);
                        got_cnt[b]++;
                    end
                end
                held[b] = vld[b] & ~rdy[b];
                held_val[b] = got[b];
            end
        end
    end

    task automatic wait_requests;
        int n;
        n = 0;
        while (got_cnt[0] < exp_cnt[0] || got_cnt[1] < exp_cnt[1] ||
               got_cnt[2] < exp_cnt[2]) begin
            n++;
            assert (n < 200000) else fail_run("timeout waiting for row requests");
            @(negedge clk);
        end
    endtask

    task automatic wait_done;
        logic [31:0] st;
        int n;
        n = 0;
        axi_read(tile_pkg::reg_status, st);
        while (!st[1]) begin
            n++;
            assert (n < 50) else fail_run("timeout waiting for the done flag");
            axi_read(tile_pkg::reg_status, st);
        end
        // done with busy low
        check_reg("status", st, 32'h2);
        // idle lanes afterwards
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic [31:0] rd;
        clk = 1'b0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rdy = '0;
        cfg_st = 32'h7b47;
        rdy_st = 32'h7b47;
        for (int b = 0; b < 3; b++) begin
            exp_cnt[b] = 0;
            got_cnt[b] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        check_reg("req_valid", 32'(vld), 32'h0);
        check_reg("bvalid", 32'(bvalid), 32'h0);
        check_reg("rvalid", 32'(rvalid), 32'h0);
        for (int idx = 0; idx < layers; idx++) begin
            draw_layer(idx);
            axi_write(tile_pkg::reg_ix, 32'(lx));
            axi_write(tile_pkg::reg_iy, 32'(ly));
            axi_write(tile_pkg::reg_kernel, {20'b0, 4'(lp), 4'(s_wr), 4'(lk)});
            axi_write(tile_pkg::reg_tile, {16'(lpoy), 16'(lpox)});
            axi_write(tile_pkg::reg_out, {16'(loy), 16'(lox)});
            // readback
            axi_read(tile_pkg::reg_ix, rd);
            check_reg("ix", rd, 32'(lx));
            axi_read(tile_pkg::reg_iy, rd);
            check_reg("iy", rd, 32'(ly));
            axi_read(tile_pkg::reg_kernel, rd);
            check_reg("kernel", rd, {20'b0, 4'(lp), 4'(ls), 4'(lk)});
            axi_read(tile_pkg::reg_tile, rd);
            check_reg("tile", rd, {16'(lpoy), 16'(lpox)});
            axi_read(tile_pkg::reg_out, rd);
            check_reg("out", rd, {16'(loy), 16'(lox)});
            axi_read(tile_pkg::reg_ctrl, rd);
            check_reg("ctrl", rd, 32'h0);
            axi_read(8'h1c, rd);
            check_reg("unmapped 0x1c", rd, 32'h0);
            axi_read(8'h80, rd);
            check_reg("unmapped 0x80", rd, 32'h0);
            axi_read(tile_pkg::reg_status, rd);
            check_reg("status", rd, (idx == 0) ? 32'h0 : 32'h2);
            build_model();
            axi_write(tile_pkg::reg_ctrl, 32'h1);
            // busy set, old done cleared
            axi_read(tile_pkg::reg_status, rd);
            check_reg("status", rd, 32'h1);
            wait_requests();
            wait_done();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
